// File: project.f
hw/alu_pkg.sv
hw/alu_stage_reg.sv
hw/alu_decode.sv
hw/alu_execute.sv
hw/alu_flags.sv
hw/alu_pipe_top.sv
tb/alu_sva.sv
tb/alu_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run the ALU testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module alu_tb -f project.f -o alu_sim || exit 1
out=$(./obj_dir/alu_sim 2>&1)
echo "$out"
echo "$out" | grep -q "^Simulation passed$" && exit 0 || exit 1

// File: tb/alu_tb.sv
`default_nettype none

module alu_tb import alu_pkg::*; ();

	logic     clk = 1'b0;
	logic     arst_n;
	logic     in_valid;
	logic     in_ready;
	alu_req_t in_req;
	logic     out_valid;
	logic     out_ready;
	alu_rsp_t out_rsp;

	int clk_period   = 40;
	int reset_cycles = 4;
	// Requests per test, used for the watchdog limit
	int n_directed   = 65;
	int n_burst      = 64;
	int n_stream     = 500;

	int    seed = 9095;
	int    cyc = 0;
	logic  ready_random = 1'b0;
	logic  lat_check = 1'b1;
	string cur_test = "reset";
	int    errors = 0;
	int    checks = 0;
	int    test_first_error;
	int    tests_passed = 0;
	int    tests_failed = 0;

	alu_rsp_t exp_q[$];
	int       acc_q[$];

	logic [31:0] pat_x [5] = '{32'h0, 32'hffff_ffff, 32'h0, 32'ha5a5_a5a5, 32'h1234_5678};
	logic [31:0] pat_y [5] = '{32'h0, 32'hffff_ffff, 32'hffff_ffff, 32'h5a5a_0ff0, 32'h1234_5678};
	// Upper bits of the last-but-one amount are set on purpose, only 5..0 count
	logic [31:0] amounts [6] = '{32'd0, 32'd1, 32'd31, 32'd32, 32'hffff_ff2d, 32'd63};

	alu_pipe_top dut0 (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_rsp   (out_rsp)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic alu_rsp_t alu_model(input alu_req_t r);
		alu_rsp_t           m;
		logic signed [63:0] sx;
		logic signed [63:0] sy;
		logic signed [63:0] wide;
		logic [63:0]        ux;
		logic [63:0]        tmp;
		logic [5:0]         amt;
		logic               reserved;
		sx = {{32{r.x[31]}}, r.x};
		sy = {{32{r.y[31]}}, r.y};
		ux = {32'd0, r.x};
		amt = r.y[5:0];
		wide = '0;
		tmp = '0;
		reserved = 1'b0;
		m = '0;
		case (r.op)
			op_and: m.z = r.x & r.y;
			op_or:  m.z = r.x | r.y;
			op_xor: m.z = r.x ^ r.y;
			op_nor: m.z = ~(r.x | r.y);
			op_add, op_sub: begin
				wide = (r.op == op_add) ? sx + sy : sx - sy;
				m.z = wide[31:0];
				// Exact result outside the 32-bit signed range
				m.of = (wide > 64'sh7fff_ffff) || (wide < -64'sh8000_0000);
			end
			op_slt: m.z = (sx < sy) ? 32'd1 : 32'd0;
			op_srl: begin
				tmp = ux >> amt;
				m.z = tmp[31:0];
			end
			op_sll: begin
				tmp = ux << amt;
				m.z = tmp[31:0];
			end
			op_sra: begin
				tmp = sx >>> amt;
				m.z = tmp[31:0];
			end
			default: reserved = 1'b1;
		endcase
		m.equal = (r.x == r.y);
		m.zero = (m.z == 32'd0) && !reserved;
		return m;
	endfunction

	function automatic string format_rsp(input alu_rsp_t r);
		return $sformatf("z=%h of=%b equal=%b zero=%b", r.z, r.of, r.equal, r.zero);
	endfunction

	//////////////////////////////////////////////////
	// Scoreboard
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		if (arst_n && in_valid && in_ready) begin
			exp_q.push_back(alu_model(in_req));
			acc_q.push_back(cyc);
		end
	end

	always @(posedge clk) begin
		alu_rsp_t want;
		int       acc;
		if (arst_n && out_valid && out_ready) begin
			if (exp_q.size() == 0) begin
				$display("Error in %s: a response arrived with no request pending", cur_test);
				errors++;
			end else begin
				want = exp_q.pop_front();
				acc = acc_q.pop_front();
				checks++;
				if (out_rsp !== want) begin
					$display("FAIL %s: expected %s, actual %s", cur_test,
						format_rsp(want), format_rsp(out_rsp));
					errors++;
				end
				// Visible after edge k+2, taken at edge k+3
				if (lat_check && (cyc - acc) != 3) begin
					$display("FAIL %s: expected latency 2, actual latency %0d", cur_test,
						cyc - acc - 1);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Driver tasks
	//////////////////////////////////////////////////

	task automatic drive_ready();
		int rnd;
		forever begin
			@(posedge clk);
			rnd = $random(seed);
			out_ready <= ready_random ? rnd[0] : 1'b1;
		end
	endtask

	task automatic send_req(input logic [31:0] x, input logic [31:0] y, input logic [3:0] code);
		alu_req_t r;
		r.x = x;
		r.y = y;
		r.op = alu_op_e'(code);
		in_valid <= 1'b1;
		in_req <= r;
		@(posedge clk);
		while (!in_ready) begin
			@(posedge clk);
		end
	endtask

	task automatic send_random(input logic idle_gaps);
		logic [31:0] x;
		logic [31:0] y;
		int          sel;
		x = $random(seed);
		y = $random(seed);
		sel = $random(seed);
		if (sel[6:4] == 3'd0) begin
			y = x;
		end
		if (idle_gaps && sel[9:8] == 2'd0) begin
			in_valid <= 1'b0;
			@(posedge clk);
		end
		send_req(x, y, sel[3:0]);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_first_error = errors;
	endtask

	task automatic finish_test();
		in_valid <= 1'b0;
		@(posedge clk);
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		if (errors == test_first_error) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
		$display("Test %s done, %0d errors", cur_test, errors - test_first_error);
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	initial begin
		arst_n = 1'b1;
		in_valid = 1'b0;
		in_req = '0;
		out_ready = 1'b1;
		fork
			drive_ready();
		join_none
		#5;
		arst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		start_test("logic");
		for (int i = 0; i < 5; i++) begin
			for (int o = 0; o < 4; o++) begin
				send_req(pat_x[i], pat_y[i], 4'(o));
			end
		end
		finish_test();

		start_test("arith");
		send_req(32'h7fff_ffff, 32'h1, op_add);
		send_req(32'h8000_0000, 32'hffff_ffff, op_add);
		send_req(32'h1, 32'h2, op_add);
		send_req(32'hffff_ffff, 32'h1, op_add);
		send_req(32'h7fff_ffff, 32'h8000_0000, op_add);
		send_req(32'h8000_0000, 32'h1, op_sub);
		send_req(32'h7fff_ffff, 32'hffff_ffff, op_sub);
		send_req(32'h5, 32'h3, op_sub);
		send_req(32'h3, 32'h5, op_sub);
		send_req(32'h8000_0000, 32'h8000_0000, op_sub);
		// Overflowing operands on non-arithmetic ops
		send_req(32'h7fff_ffff, 32'h1, op_xor);
		send_req(32'h8000_0000, 32'hffff_ffff, op_slt);
		finish_test();

		start_test("compare");
		send_req(32'hffff_ffff, 32'h1, op_slt);
		send_req(32'h1, 32'hffff_ffff, op_slt);
		send_req(32'h8000_0000, 32'h7fff_ffff, op_slt);
		send_req(32'h7fff_ffff, 32'h8000_0000, op_slt);
		send_req(32'h5, 32'h5, op_slt);
		send_req(32'h9, 32'h9, op_add);
		send_req(32'h9, 32'h9, op_sub);
		send_req(32'hc, 32'hc, op_or);
		finish_test();

		start_test("shift");
		for (int o = 8; o <= 10; o++) begin
			for (int a = 0; a < 6; a++) begin
				send_req(32'h8000_00f1, amounts[a], 4'(o));
			end
		end
		send_req(32'h7000_0001, 32'd40, op_sra);
		finish_test();

		// Operands that overflow the adder, so of must stay gated off
		start_test("reserved");
		send_req(32'h8000_0000, 32'h8000_0000, 4'd4);
		for (int c = 11; c <= 15; c++) begin
			send_req(32'h8000_0000, 32'h8000_0000, 4'(c));
		end
		finish_test();

		start_test("burst");
		for (int n = 0; n < n_burst; n++) begin
			send_random(1'b0);
		end
		finish_test();

		// Random back-pressure, order and values only
		lat_check = 1'b0;
		ready_random = 1'b1;
		start_test("stream");
		for (int n = 0; n < n_stream; n++) begin
			send_random(1'b1);
		end
		finish_test();

		$display("Tests: %0d passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, checks, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	//////////////////////////////////////////////////
	// Watchdog
	//////////////////////////////////////////////////

	initial begin
		int limit;
		limit = (n_directed + n_burst + n_stream) * clk_period * 8 + reset_cycles * clk_period;
		#(limit);
		$display("Watchdog: the run timed out before all responses arrived");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/alu_sva.sv
`default_nettype none

module alu_sva import alu_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     in_valid,
	input logic     in_ready,
	input alu_req_t in_req,
	input logic     out_valid,
	input logic     out_ready,
	input alu_rsp_t out_rsp
);

	// No output while the pipeline is held in reset
	assert property (@(posedge clk) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// Stalled response must hold its payload
	assert property (@(posedge clk) disable iff (!arst_n)
		(out_valid && !out_ready) |=> $stable(out_rsp))
		else $error("out_rsp changed while stalled");

	// Stalled request must hold its payload
	assert property (@(posedge clk) disable iff (!arst_n)
		(in_valid && !in_ready) |=> $stable(in_req))
		else $error("in_req changed while stalled");

endmodule

bind alu_pipe_top alu_sva u_sva (
	.clk       (clk),
	.arst_n    (arst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.in_req    (in_req),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_rsp   (out_rsp)
);

`default_nettype wire

// File: hw/alu_pipe_top.sv
`default_nettype none

module alu_pipe_top import alu_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  alu_req_t in_req,
	output logic     out_valid,
	input  logic     out_ready,
	output alu_rsp_t out_rsp
);

	alu_dec_t dec_d;
	alu_dec_t dec_q;
	logic     dec_valid;
	logic     dec_ready;

	alu_exe_t exe_d;
	alu_exe_t exe_q;
	logic     exe_valid;
	logic     exe_ready;

	alu_rsp_t rsp_d;

	//////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////

	alu_decode u_decode (
		.req (in_req),
		.dec (dec_d)
	);

	alu_stage_reg #(
		.payload_t (alu_dec_t)
	) u_stage_dec (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_data   (dec_d),
		.out_valid (dec_valid),
		.out_ready (dec_ready),
		.out_data  (dec_q)
	);

	//////////////////////////////////////////////////
	// Execute
	//////////////////////////////////////////////////

	alu_execute u_execute (
		.dec (dec_q),
		.exe (exe_d)
	);

	alu_stage_reg #(
		.payload_t (alu_exe_t)
	) u_stage_exe (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (dec_valid),
		.in_ready  (dec_ready),
		.in_data   (exe_d),
		.out_valid (exe_valid),
		.out_ready (exe_ready),
		.out_data  (exe_q)
	);

	//////////////////////////////////////////////////
	// Flags and output register
	//////////////////////////////////////////////////

	alu_flags u_flags (
		.exe (exe_q),
		.rsp (rsp_d)
	);

	alu_stage_reg #(
		.payload_t (alu_rsp_t)
	) u_stage_rsp (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (exe_valid),
		.in_ready  (exe_ready),
		.in_data   (rsp_d),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_rsp)
	);

endmodule

`default_nettype wire

// File: hw/alu_flags.sv
`default_nettype none

module alu_flags import alu_pkg::*; (
	input  alu_exe_t exe,
	output alu_rsp_t rsp
);

	logic z_is_zero;

	assign z_is_zero = ~(|exe.z);

	always_comb begin
		rsp.z     = exe.z;
		rsp.equal = exe.equal;

		// Overflow only means something for add and sub
		rsp.of    = exe.raw_of & (exe.unit == unit_arith);

		// Reserved codes give z of 0 but never raise zero
		rsp.zero  = z_is_zero & ~exe.reserved;
	end

endmodule

`default_nettype wire

// File: hw/alu_execute.sv
`default_nettype none

module alu_execute import alu_pkg::*; (
	input  alu_dec_t dec,
	output alu_exe_t exe
);

	logic [alu_width-1:0] logic_z;
	logic [alu_width-1:0] add_y;
	logic [alu_width-1:0] add_z;
	logic                 add_of;
	logic [alu_width-1:0] slt_z;
	logic [alu_width-1:0] srl_z;
	logic [alu_width-1:0] sll_z;
	logic [alu_width-1:0] sra_z;
	logic [alu_width-1:0] shift_z;

	//////////////////////////////////////////////////
	// Logic unit
	//////////////////////////////////////////////////

	always_comb begin
		case (dec.op)
			op_and:  logic_z = dec.x & dec.y;
			op_or:   logic_z = dec.x | dec.y;
			op_xor:  logic_z = dec.x ^ dec.y;
			op_nor:  logic_z = ~(dec.x | dec.y);
			default: logic_z = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Adder / subtractor
	//////////////////////////////////////////////////

	// x - y as x + ~y + 1
	assign add_y = dec.sub ? ~dec.y : dec.y;
	assign add_z = dec.x + add_y + {{(alu_width-1){1'b0}}, dec.sub};

	// Same-sign addends with a sum of the other sign
	assign add_of = (dec.x[alu_width-1] == add_y[alu_width-1]) &&
	                (add_z[alu_width-1] != dec.x[alu_width-1]);

	//////////////////////////////////////////////////
	// Signed compare
	//////////////////////////////////////////////////

	always_comb begin
		slt_z = '0;
		if ($signed(dec.x) < $signed(dec.y)) begin
			slt_z[0] = 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Shifter
	//////////////////////////////////////////////////

	always_comb begin
		if (dec.shift_over) begin
			srl_z = '0;
			sll_z = '0;
			// All sign bits once the amount passes the width
			sra_z = {alu_width{dec.x[alu_width-1]}};
		end else begin
			srl_z = dec.x >> dec.shamt;
			sll_z = dec.x << dec.shamt;
			sra_z = $signed(dec.x) >>> dec.shamt;
		end
	end

	always_comb begin
		case (dec.op)
			op_srl:  shift_z = srl_z;
			op_sll:  shift_z = sll_z;
			op_sra:  shift_z = sra_z;
			default: shift_z = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////

	always_comb begin
		case (dec.unit)
			unit_logic:   exe.z = logic_z;
			unit_arith:   exe.z = add_z;
			unit_compare: exe.z = slt_z;
			unit_shift:   exe.z = shift_z;
			default:      exe.z = '0;
		endcase

		exe.unit     = dec.unit;
		exe.raw_of   = add_of;
		// Independent of the operation
		exe.equal    = (dec.x == dec.y);
		exe.reserved = dec.reserved;
	end

endmodule

`default_nettype wire

// File: hw/alu_decode.sv
`default_nettype none

module alu_decode import alu_pkg::*; (
	input  alu_req_t req,
	output alu_dec_t dec
);

	alu_unit_e unit;
	logic      reserved;

	//////////////////////////////////////////////////
	// Unit select
	//////////////////////////////////////////////////

	always_comb begin
		unit     = unit_none;
		reserved = 1'b0;
		case (req.op)
			op_and,
			op_or,
			op_xor,
			op_nor: begin
				unit = unit_logic;
			end
			op_add,
			op_sub: begin
				unit = unit_arith;
			end
			op_slt: begin
				unit = unit_compare;
			end
			op_srl,
			op_sll,
			op_sra: begin
				unit = unit_shift;
			end
			default: begin
				// 4 and 11..15
				unit     = unit_none;
				reserved = 1'b1;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Decoded payload
	//////////////////////////////////////////////////

	always_comb begin
		dec.x        = req.x;
		dec.y        = req.y;
		dec.op       = req.op;
		dec.unit     = unit;
		dec.reserved = reserved;
		// One adder, subtract flag picks inversion and carry in
		dec.sub      = (req.op == op_sub);

		// 6-bit shift field, amounts of 32 and up flagged
		dec.shamt      = req.y[alu_shamt_w-1:0];
		dec.shift_over = (req.y[alu_shamt_w:0] >= (alu_shamt_w + 1)'(alu_width));
	end

endmodule

`default_nettype wire

// File: hw/alu_stage_reg.sv
`default_nettype none

module alu_stage_reg import alu_pkg::*; #(
	parameter type payload_t = alu_rsp_t
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	logic     valid_q;
	payload_t data_q;

	// Take new data when empty or when the current item leaves
	assign in_ready = ~valid_q | out_ready;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else if (in_ready) begin
			valid_q <= in_valid;
		end
	end

	// Payload only
	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			data_q <= in_data;
		end
	end

	assign out_valid = valid_q;
	assign out_data  = data_q;

endmodule

`default_nettype wire

// File: hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int alu_width  = 32;
	// Shift amount field inside y
	localparam int alu_shamt_w = $clog2(alu_width);

	//////////////////////////////////////////////////
	// Operation codes and unit select
	//////////////////////////////////////////////////

	// Codes 4 and 11 to 15 are reserved and have no entry
	typedef enum logic [3:0] {
		op_and = 4'd0,
		op_or  = 4'd1,
		op_xor = 4'd2,
		op_nor = 4'd3,
		op_add = 4'd5,
		op_sub = 4'd6,
		op_slt = 4'd7,
		op_srl = 4'd8,
		op_sll = 4'd9,
		op_sra = 4'd10
	} alu_op_e;

	typedef enum logic [2:0] {
		unit_logic   = 3'd0,
		unit_arith   = 3'd1,
		unit_compare = 3'd2,
		unit_shift   = 3'd3,
		unit_none    = 3'd4
	} alu_unit_e;

	//////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [alu_width-1:0] x;
		logic [alu_width-1:0] y;
		alu_op_e              op;
	} alu_req_t;

	typedef struct packed {
		logic [alu_width-1:0]   x;
		logic [alu_width-1:0]   y;
		alu_op_e                op;
		alu_unit_e              unit;
		logic                   sub;
		logic [alu_shamt_w-1:0] shamt;
		logic                   shift_over;
		logic                   reserved;
	} alu_dec_t;

	typedef struct packed {
		logic [alu_width-1:0] z;
		alu_unit_e            unit;
		logic                 raw_of;
		logic                 equal;
		logic                 reserved;
	} alu_exe_t;

	typedef struct packed {
		logic [alu_width-1:0] z;
		logic                 of;
		logic                 equal;
		logic                 zero;
	} alu_rsp_t;

endpackage

`default_nettype wire
